//--- Bender.yml
package:
  name: mips_control

export_include_dirs:
  - .

sources:
  - mipsCtrlPkg.sv
  - instrDecoder.sv
  - stepSequencer.sv
  - controlEncoder.sv
  - mipsControl.sv
  - target: test
    include_dirs:
      - .
    files:
      - mipsControlTb.sv

//--- controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder
    import mipsCtrlPkg::*;
#(
    parameter int StepWidth = 2
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [PhaseWidth-1:0]     phase,
    input  logic [StepWidth-1:0]      step,
    output logic                      pcWrite,
    output logic                      irWrite,
    output logic                      regWrite,
    output logic                      aWrite,
    output logic                      bWrite,
    output logic                      aluOutWrite,
    output logic [AluOpWidth-1:0]     aluOp,
    output logic                      srcASel,
    output logic [SrcBWidth-1:0]      srcBSel,
    output logic [RegDestWidth-1:0]   regDestSel,
    output logic [MemToRegWidth-1:0]  memToRegSel,
    output logic                      pcSrcSel,
    output logic                      shiftAmtSel,
    output logic                      shiftSrcSel,
    output logic [ShiftCtrlWidth-1:0] shiftCtrl,
    output logic                      resetOut
);

    always_comb begin
        pcWrite = 1'b0;
        irWrite = 1'b0;
        regWrite = 1'b0;
        aWrite = 1'b0;
        bWrite = 1'b0;
        aluOutWrite = 1'b0;
        aluOp = aluNone;
        srcASel = 1'b0;
        srcBSel = srcBReg;
        regDestSel = destRt;
        memToRegSel = wbAluOut;
        pcSrcSel = 1'b0;
        shiftAmtSel = 1'b0;
        shiftSrcSel = 1'b0;
        shiftCtrl = shiftIdle;
        resetOut = reset || (phase == phHalt);

        if (!reset) begin
            case (phase)
                // alu computes pc + 4 while memory is busy
                phFetchWait: begin
                    aluOp = aluAdd;
                    srcBSel = srcBFour;
                end
                phFetchLatch: begin
                    aluOp = aluAdd;
                    srcBSel = srcBFour;
                    pcWrite = 1'b1;
                    irWrite = 1'b1;
                end
                phRegRead: begin
                    aWrite = 1'b1;
                    bWrite = 1'b1;
                end
                phAdd, phSub, phAnd: begin
                    srcASel = 1'b1;
                    aluOutWrite = 1'b1;
                    regDestSel = destRd;
                    regWrite = (step == StepWidth'(1));
                    case (phase)
                        phSub:   aluOp = aluSub;
                        phAnd:   aluOp = aluAnd;
                        default: aluOp = aluAdd;
                    endcase
                end
                phAddi: begin
                    srcASel = 1'b1;
                    srcBSel = srcBImm;
                    aluOutWrite = 1'b1;
                    aluOp = aluAdd;
                    regWrite = (step == StepWidth'(1));
                end
                // load the shifter, then two shift steps, result on the last
                phSll: begin
                    regDestSel = destRd;
                    if (step == '0) begin
                        shiftCtrl = shiftLoad;
                        shiftAmtSel = 1'b1;
                        shiftSrcSel = 1'b1;
                    end else begin
                        shiftCtrl = shiftLeft;
                    end
                    if (step == StepWidth'(2)) begin
                        regWrite = 1'b1;
                        memToRegSel = wbShift;
                    end
                end
                phSlt: begin
                    srcASel = 1'b1;
                    aluOp = aluSlt;
                    regDestSel = destRd;
                    memToRegSel = wbSlt;
                    regWrite = 1'b1;
                end
                phJ: begin
                    pcWrite = 1'b1;
                    pcSrcSel = 1'b1;
                end
                // jump target comes from register A
                phJr: begin
                    pcWrite = 1'b1;
                    srcASel = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // a write-back never overlaps an instruction fetch
    fetchVsWriteback: assert property (
        @(posedge clock) disable iff (reset)
        !(irWrite && regWrite)
    );

endmodule

//--- flist.f
+incdir+.
mipsCtrlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlEncoder.sv
mipsControl.sv
mipsControlTb.sv

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
    import mipsCtrlPkg::*;
(
    input  logic [OpcodeWidth-1:0] opcode,
    input  offsetWord              offset,
    output logic [PhaseWidth-1:0]  execPhase
);

    logic [PhaseWidth-1:0] functPhase;

    // R-type instructions are told apart by funct alone
    always_comb begin
        case (offset.rType.funct)
            functAdd: functPhase = phAdd;
            functSub: functPhase = phSub;
            functAnd: functPhase = phAnd;
            functSll: functPhase = phSll;
            functSlt: functPhase = phSlt;
            functJr:  functPhase = phJr;
            default:  functPhase = phFetchWait;
        endcase
    end

    // unknown codes fall back to fetch, nothing gets written
    always_comb begin
        case (opcode)
            opR:     execPhase = functPhase;
            opAddi:  execPhase = phAddi;
            opJ:     execPhase = phJ;
            opHalt:  execPhase = phHalt;
            default: execPhase = phFetchWait;
        endcase
    end

endmodule

//--- mipsControl.sv
`timescale 1ns/1ps

module mipsControl
    import mipsCtrlPkg::*;
#(
    parameter int MemWaitCycles = 3
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [OpcodeWidth-1:0]    opcode,
    input  logic [OffsetWidth-1:0]    offset,
    output logic                      pcWrite,
    output logic                      irWrite,
    output logic                      regWrite,
    output logic                      aWrite,
    output logic                      bWrite,
    output logic                      aluOutWrite,
    output logic [AluOpWidth-1:0]     aluOp,
    output logic                      srcASel,
    output logic [SrcBWidth-1:0]      srcBSel,
    output logic [RegDestWidth-1:0]   regDestSel,
    output logic [MemToRegWidth-1:0]  memToRegSel,
    output logic                      pcSrcSel,
    output logic                      shiftAmtSel,
    output logic                      shiftSrcSel,
    output logic [ShiftCtrlWidth-1:0] shiftCtrl,
    output logic                      resetOut
);

    // two bits at least, so the three sll steps always fit
    localparam int StepWidth = ($clog2(MemWaitCycles) > 2) ? $clog2(MemWaitCycles) : 2;

    logic [PhaseWidth-1:0] execPhase;
    logic [PhaseWidth-1:0] phase;
    logic [StepWidth-1:0] step;

    instrDecoder i_decoder (
        .opcode   (opcode),
        .offset   (offset),
        .execPhase(execPhase)
    );

    stepSequencer #(
        .MemWaitCycles(MemWaitCycles),
        .StepWidth    (StepWidth)
    ) i_sequencer (
        .clock    (clock),
        .reset    (reset),
        .execPhase(execPhase),
        .phase    (phase),
        .step     (step)
    );

    controlEncoder #(
        .StepWidth(StepWidth)
    ) i_encoder (
        .clock      (clock),
        .reset      (reset),
        .phase      (phase),
        .step       (step),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .aWrite     (aWrite),
        .bWrite     (bWrite),
        .aluOutWrite(aluOutWrite),
        .aluOp      (aluOp),
        .srcASel    (srcASel),
        .srcBSel    (srcBSel),
        .regDestSel (regDestSel),
        .memToRegSel(memToRegSel),
        .pcSrcSel   (pcSrcSel),
        .shiftAmtSel(shiftAmtSel),
        .shiftSrcSel(shiftSrcSel),
        .shiftCtrl  (shiftCtrl),
        .resetOut   (resetOut)
    );

endmodule

//--- controlChecks.svh
`ifndef CONTROL_CHECKS_SVH
`define CONTROL_CHECKS_SVH

int errorCount = 0;

task automatic strobeCheck(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errorCount++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic aluOpCheck(input string name, input logic [AluOpWidth-1:0] got,
                          input logic [AluOpWidth-1:0] exp);
    if (got !== exp) begin
        errorCount++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

// widest select field, narrower ones are zero extended
task automatic selectCheck(input string name, input logic [MemToRegWidth-1:0] got,
                           input logic [MemToRegWidth-1:0] exp);
    if (got !== exp) begin
        errorCount++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic cycleCheck(input string name, input int got, input int exp);
    if (got != exp) begin
        errorCount++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

`endif

//--- mipsControlTb.sv
`timescale 1ns/1ps

module mipsControlTb
    import mipsCtrlPkg::*;
();

    localparam int ClockPeriod = 10;
    localparam int MemWaitCycles = 3;
    // latch, read, decode, sll, then the next fetch wait
    localparam int MaxInstrCycles = 3 + 3 + MemWaitCycles + 1;
    // sixteen instruction slots plus halt hold and resets, doubled
    localparam int WatchdogCycles = 2 * (16 * MaxInstrCycles + 30);

    logic clock = 1'b0;
    logic reset;
    logic [OpcodeWidth-1:0] opcode;
    logic [OffsetWidth-1:0] offset;
    logic pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite;
    logic srcASel, pcSrcSel, shiftAmtSel, shiftSrcSel, resetOut;
    logic [AluOpWidth-1:0] aluOp;
    logic [SrcBWidth-1:0] srcBSel;
    logic [RegDestWidth-1:0] regDestSel;
    logic [MemToRegWidth-1:0] memToRegSel;
    logic [ShiftCtrlWidth-1:0] shiftCtrl;

    `include "controlChecks.svh"

    always #(ClockPeriod / 2) clock = ~clock;

    mipsControl i_dut (.*);

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    function automatic offsetWord rTypeOffset(input logic [FunctWidth-1:0] funct);
        offsetWord off;
        // rd and shamt are don't care for the control unit
        off.imm = 16'($urandom);
        off.rType.funct = funct;
        return off;
    endfunction

    // counts cycles up to and including the next irWrite
    task automatic waitIrWrite(input int expCycles);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (!irWrite) begin
                strobeCheck("regWrite", regWrite, 1'b0);
                strobeCheck("resetOut", resetOut, 1'b0);
                aluOpCheck("aluOp", aluOp, aluAdd);
                selectCheck("srcBSel", srcBSel, srcBFour);
            end
        end while (!irWrite && cycles < 2 * MaxInstrCycles);
        if (irWrite) begin
            cycleCheck("irWrite delay", cycles, expCycles);
        end else begin
            errorCount++;
            $display("irWrite did not arrive within %0d cycles at %0t", cycles, $time);
        end
    endtask

    // starts at the negedge of an irWrite cycle, ends at the decode cycle
    task automatic fetchInstr(input logic [OpcodeWidth-1:0] op, input offsetWord off);
        @(posedge clock);
        #1;
        opcode = op;
        offset = off;
        @(negedge clock);
        strobeCheck("irWrite", irWrite, 1'b0);
        strobeCheck("aWrite", aWrite, 1'b1);
        strobeCheck("bWrite", bWrite, 1'b1);
        @(negedge clock);
        strobeCheck("regWrite", regWrite, 1'b0);
        strobeCheck("pcWrite", pcWrite, 1'b0);
        aluOpCheck("aluOp", aluOp, aluNone);
    endtask

    task automatic execStep(input logic expRegWrite, input logic [AluOpWidth-1:0] expAlu,
                            input logic [RegDestWidth-1:0] expDest);
        @(negedge clock);
        strobeCheck("regWrite", regWrite, expRegWrite);
        strobeCheck("irWrite", irWrite, 1'b0);
        aluOpCheck("aluOp", aluOp, expAlu);
        selectCheck("regDestSel", regDestSel, expDest);
    endtask

    task automatic resetTest();
        @(negedge clock);
        strobeCheck("resetOut", resetOut, 1'b1);
        strobeCheck("irWrite", irWrite, 1'b0);
        strobeCheck("pcWrite", pcWrite, 1'b0);
        strobeCheck("regWrite", regWrite, 1'b0);
        aluOpCheck("aluOp", aluOp, aluNone);
        @(posedge clock);
        #1;
        reset = 1'b0;
        waitIrWrite(MemWaitCycles + 1);
    endtask

    task automatic arithTest(input logic [FunctWidth-1:0] funct,
                             input logic [AluOpWidth-1:0] expAlu);
        fetchInstr(opR, rTypeOffset(funct));
        execStep(1'b0, expAlu, destRd);
        strobeCheck("srcASel", srcASel, 1'b1);
        strobeCheck("aluOutWrite", aluOutWrite, 1'b1);
        execStep(1'b1, expAlu, destRd);
        strobeCheck("srcASel", srcASel, 1'b1);
        waitIrWrite(MemWaitCycles + 1);
    endtask

    task automatic addiTest();
        offsetWord off;
        off.imm = 16'($urandom);
        fetchInstr(opAddi, off);
        execStep(1'b0, aluAdd, destRt);
        selectCheck("srcBSel", srcBSel, srcBImm);
        execStep(1'b1, aluAdd, destRt);
        selectCheck("srcBSel", srcBSel, srcBImm);
        waitIrWrite(MemWaitCycles + 1);
    endtask

    task automatic shiftSltTest();
        fetchInstr(opR, rTypeOffset(functSll));
        execStep(1'b0, aluNone, destRd);
        selectCheck("shiftCtrl", shiftCtrl, shiftLoad);
        selectCheck("memToRegSel", memToRegSel, wbAluOut);
        strobeCheck("shiftAmtSel", shiftAmtSel, 1'b1);
        strobeCheck("shiftSrcSel", shiftSrcSel, 1'b1);
        execStep(1'b0, aluNone, destRd);
        selectCheck("shiftCtrl", shiftCtrl, shiftLeft);
        selectCheck("memToRegSel", memToRegSel, wbAluOut);
        execStep(1'b1, aluNone, destRd);
        selectCheck("shiftCtrl", shiftCtrl, shiftLeft);
        selectCheck("memToRegSel", memToRegSel, wbShift);
        waitIrWrite(MemWaitCycles + 1);
        fetchInstr(opR, rTypeOffset(functSlt));
        execStep(1'b1, aluSlt, destRd);
        selectCheck("memToRegSel", memToRegSel, wbSlt);
        waitIrWrite(MemWaitCycles + 1);
    endtask

    task automatic jumpTest();
        offsetWord off;
        off.imm = 16'($urandom);
        fetchInstr(opJ, off);
        execStep(1'b0, aluNone, destRt);
        strobeCheck("pcWrite", pcWrite, 1'b1);
        strobeCheck("pcSrcSel", pcSrcSel, 1'b1);
        waitIrWrite(MemWaitCycles + 1);
        fetchInstr(opR, rTypeOffset(functJr));
        execStep(1'b0, aluNone, destRt);
        strobeCheck("pcWrite", pcWrite, 1'b1);
        strobeCheck("srcASel", srcASel, 1'b1);
        strobeCheck("pcSrcSel", pcSrcSel, 1'b0);
        waitIrWrite(MemWaitCycles + 1);
    endtask

    task automatic unknownHaltTest();
        // funct 63 and opcode 4 are not implemented, straight back to fetch
        fetchInstr(opR, rTypeOffset(6'd63));
        waitIrWrite(MemWaitCycles + 1);
        fetchInstr(6'd4, rTypeOffset(functAdd));
        waitIrWrite(MemWaitCycles + 1);
        fetchInstr(opHalt, rTypeOffset(functAdd));
        repeat (2 * MaxInstrCycles) begin
            @(negedge clock);
            strobeCheck("resetOut", resetOut, 1'b1);
            strobeCheck("irWrite", irWrite, 1'b0);
            strobeCheck("pcWrite", pcWrite, 1'b0);
            strobeCheck("regWrite", regWrite, 1'b0);
        end
        @(posedge clock);
        #1;
        reset = 1'b1;
        @(posedge clock);
        #1;
        reset = 1'b0;
        waitIrWrite(MemWaitCycles + 1);
        arithTest(functAdd, aluAdd);
    endtask

    initial begin
        void'($urandom(91054));
        reset = 1'b1;
        opcode = '0;
        offset = '0;
        resetTest();
        arithTest(functAdd, aluAdd);
        arithTest(functSub, aluSub);
        arithTest(functAnd, aluAnd);
        addiTest();
        shiftSltTest();
        jumpTest();
        unknownHaltTest();
        $display("run complete with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- mipsCtrlPkg.sv
package mipsCtrlPkg;

    // instruction fields
    localparam int OpcodeWidth = 6;
    localparam int FunctWidth = 6;
    localparam int OffsetWidth = 16;

    localparam logic [OpcodeWidth-1:0] opR = 6'd0;
    localparam logic [OpcodeWidth-1:0] opJ = 6'd2;
    localparam logic [OpcodeWidth-1:0] opAddi = 6'd8;
    localparam logic [OpcodeWidth-1:0] opHalt = 6'd63;

    localparam logic [FunctWidth-1:0] functSll = 6'd0;
    localparam logic [FunctWidth-1:0] functJr = 6'd8;
    localparam logic [FunctWidth-1:0] functAdd = 6'd32;
    localparam logic [FunctWidth-1:0] functSub = 6'd34;
    localparam logic [FunctWidth-1:0] functAnd = 6'd36;
    localparam logic [FunctWidth-1:0] functSlt = 6'd42;

    // sequencer phases
    localparam int PhaseWidth = 4;

    localparam logic [PhaseWidth-1:0] phFetchWait = 4'd0;
    localparam logic [PhaseWidth-1:0] phFetchLatch = 4'd1;
    localparam logic [PhaseWidth-1:0] phRegRead = 4'd2;
    localparam logic [PhaseWidth-1:0] phDecode = 4'd3;
    localparam logic [PhaseWidth-1:0] phAdd = 4'd4;
    localparam logic [PhaseWidth-1:0] phSub = 4'd5;
    localparam logic [PhaseWidth-1:0] phAnd = 4'd6;
    localparam logic [PhaseWidth-1:0] phAddi = 4'd7;
    localparam logic [PhaseWidth-1:0] phSll = 4'd8;
    localparam logic [PhaseWidth-1:0] phSlt = 4'd9;
    localparam logic [PhaseWidth-1:0] phJ = 4'd10;
    localparam logic [PhaseWidth-1:0] phJr = 4'd11;
    localparam logic [PhaseWidth-1:0] phHalt = 4'd12;

    // control word fields
    localparam int AluOpWidth = 3;
    localparam int SrcBWidth = 2;
    localparam int RegDestWidth = 2;
    localparam int MemToRegWidth = 4;
    localparam int ShiftCtrlWidth = 3;

    localparam logic [AluOpWidth-1:0] aluNone = 3'd0;
    localparam logic [AluOpWidth-1:0] aluAdd = 3'd1;
    localparam logic [AluOpWidth-1:0] aluSub = 3'd2;
    localparam logic [AluOpWidth-1:0] aluAnd = 3'd3;
    localparam logic [AluOpWidth-1:0] aluSlt = 3'd7;

    localparam logic [SrcBWidth-1:0] srcBReg = 2'd0;
    localparam logic [SrcBWidth-1:0] srcBFour = 2'd1;
    localparam logic [SrcBWidth-1:0] srcBImm = 2'd2;

    localparam logic [RegDestWidth-1:0] destRt = 2'd0;
    localparam logic [RegDestWidth-1:0] destRd = 2'd1;

    localparam logic [MemToRegWidth-1:0] wbAluOut = 4'd0;
    localparam logic [MemToRegWidth-1:0] wbSlt = 4'd4;
    localparam logic [MemToRegWidth-1:0] wbShift = 4'd8;

    localparam logic [ShiftCtrlWidth-1:0] shiftIdle = 3'd0;
    localparam logic [ShiftCtrlWidth-1:0] shiftLoad = 3'd1;
    localparam logic [ShiftCtrlWidth-1:0] shiftLeft = 3'd2;

    // low half of the instruction, R-type fields or I-type immediate
    typedef union packed {
        struct packed {
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [FunctWidth-1:0] funct;
        } rType;
        logic [OffsetWidth-1:0] imm;
    } offsetWord;

endpackage

//--- stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer
    import mipsCtrlPkg::*;
#(
    parameter int MemWaitCycles = 3,
    parameter int StepWidth = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [PhaseWidth-1:0] execPhase,
    output logic [PhaseWidth-1:0] phase,
    output logic [StepWidth-1:0]  step
);

    localparam logic [StepWidth-1:0] LastWait = StepWidth'(MemWaitCycles - 1);
    // sll is the longest execute phase at three steps
    localparam int StepLimit = (MemWaitCycles > 3) ? MemWaitCycles : 3;

    logic [StepWidth-1:0] lastStep;
    logic [PhaseWidth-1:0] nextPhase;

    // final step index of the current phase
    always_comb begin
        case (phase)
            phFetchWait:                lastStep = LastWait;
            phAdd, phSub, phAnd, phAddi: lastStep = StepWidth'(1);
            phSll:                      lastStep = StepWidth'(2);
            default:                    lastStep = '0;
        endcase
    end

    // where the phase goes once its last step is done
    always_comb begin
        case (phase)
            phFetchWait:  nextPhase = phFetchLatch;
            phFetchLatch: nextPhase = phRegRead;
            phRegRead:    nextPhase = phDecode;
            phDecode:     nextPhase = execPhase;
            phHalt:       nextPhase = phHalt;
            default:      nextPhase = phFetchWait;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= phFetchWait;
            step <= '0;
        end else if (step == lastStep) begin
            phase <= nextPhase;
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    // the wait counter must wrap before the memory latency is exceeded
    stepBound: assert property (
        @(posedge clock) disable iff (reset)
        step < StepLimit
    );

    // halt is sticky, only reset brings the unit back to fetch
    haltHold: assert property (
        @(posedge clock) disable iff (reset)
        phase == phHalt |=> phase == phHalt
    );

endmodule
